// File: include/pipe_consts.svh
/*
 * pipeline constants
 * widths and depths for the five-stage core and its retirement tracker
 */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// instruction word, opcode 15..12, rd 11..10, rs 9..8, imm 7..0
`define INSTR_W     16
// register file and data path width
`define DATA_W      8
// program counter, covers the whole instruction memory
`define PC_W        5
`define IMEM_DEPTH  32
// data memory is addressed by the low bits of rs plus imm
`define DMEM_DEPTH  16
`define REG_CNT     4

////////////////////////////////////////////////////////////
// retirement record widths
////////////////////////////////////////////////////////////
`define TAG_W       8
`define CYC_W       16
// stall count saturates at all ones
`define STALL_W     4

`endif

// File: logic/pipe_pkg.sv
/*
 * pipe_pkg
 * opcode and run-state types shared by the pipeline stages
 */
package pipe_pkg;

    // opcode field of the instruction word
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_addi = 4'h1,
        op_add  = 4'h2,
        op_sub  = 4'h3,
        op_ld   = 4'h4,
        op_st   = 4'h5,
        op_beqz = 4'h6,
        op_halt = 4'h7
    } opcode_t;

    // core run state, idle until start, halted after op_halt
    typedef enum logic [1:0] {
        run_idle   = 2'b00,
        run_active = 2'b01,
        run_halted = 2'b10
    } run_state_t;

    // opcodes that write rd at writeback
    function automatic logic op_writes(opcode_t op);
        return op inside {op_addi, op_add, op_sub, op_ld};
    endfunction

endpackage

// File: logic/fetch_unit.sv
/*
 * fetch unit
 * program counter, instruction memory with program write port,
 * halt hold and branch redirect
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module fetch_unit import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 prog_we,
    input  logic [`PC_W-1:0]     prog_addr,
    input  logic [`INSTR_W-1:0]  prog_data,
    input  logic                 stall,
    input  logic                 flush,
    input  logic [`PC_W-1:0]     branch_target,
    output logic [`INSTR_W-1:0]  instr,
    output logic [`PC_W-1:0]     fetch_pc,
    output logic                 fetch_valid
);

    logic [`INSTR_W-1:0] imem [`IMEM_DEPTH];
    logic [`PC_W-1:0]    pc;
    run_state_t          state;
    opcode_t             cur_op;

    // opcode of the word the pc points at this cycle
    assign cur_op = opcode_t'(imem[pc][15:12]);

    // program load only while the core sits idle
    always_ff @(posedge clk) begin
        if (prog_we && state == run_idle) begin
            imem[prog_addr] <= prog_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // pc and run state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= run_idle;
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else if (flush) begin
            // redirect, the word in flight is dropped
            pc          <= branch_target;
            fetch_valid <= 1'b0;
            state       <= run_active;
        end else if (!stall) begin
            fetch_valid <= 1'b0;
            case (state)
                run_idle: begin
                    if (start) begin
                        state <= run_active;
                        pc    <= '0;
                    end
                end
                run_active: begin
                    fetch_valid <= 1'b1;
                    pc          <= pc + 1'b1;
                    // nothing fetched past a halt
                    if (cur_op == op_halt) begin
                        state <= run_halted;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // fetch/decode payload, frozen by stall
    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            instr    <= imem[pc];
            fetch_pc <= pc;
        end
    end

endmodule

// File: logic/decode_unit.sv
/*
 * decode unit
 * register file with write-first read, operand fetch, hazard stall
 * and the decode/execute pipeline register
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module decode_unit import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`INSTR_W-1:0]  instr,
    input  logic [`PC_W-1:0]     fetch_pc,
    input  logic                 fetch_valid,
    input  logic                 flush,
    input  logic                 wb_we,
    input  logic [1:0]           wb_rd,
    input  logic [`DATA_W-1:0]   wb_data,
    output opcode_t              ex_op,
    output logic [1:0]           ex_rd,
    output logic [`DATA_W-1:0]   ex_a,
    output logic [`DATA_W-1:0]   ex_b,
    output logic [7:0]           ex_imm,
    output logic [`PC_W-1:0]     ex_pc,
    output logic                 ex_valid,
    output logic                 stall
);

    logic [`DATA_W-1:0] regs [`REG_CNT];
    opcode_t            d_op;
    logic [1:0]         d_rd;
    logic [1:0]         d_rs;
    logic [`DATA_W-1:0] rd_val;
    logic [`DATA_W-1:0] rs_val;
    logic               reads_rd;
    logic               reads_rs;
    logic               haz_rd;
    logic               haz_rs;
    logic               advance;
    // destination copies for execute and memory
    logic               ex_wr;
    logic               mem_wr;
    logic [1:0]         mem_dst;

    // field split
    assign d_op = opcode_t'(instr[15:12]);
    assign d_rd = instr[11:10];
    assign d_rs = instr[9:8];

    // source usage per opcode, st needs rs for its address
    assign reads_rd = d_op inside {op_add, op_sub, op_st, op_beqz};
    assign reads_rs = d_op inside {op_addi, op_add, op_sub, op_ld, op_st};

    // writeback value wins over the stored one
    assign rd_val = (wb_we && wb_rd == d_rd) ? wb_data : regs[d_rd];
    assign rs_val = (wb_we && wb_rd == d_rs) ? wb_data : regs[d_rs];

    ////////////////////////////////////////////////////////////
    // hazard check, no forwarding so wait for writeback
    ////////////////////////////////////////////////////////////
    assign haz_rd = reads_rd && ((ex_wr && ex_rd == d_rd) || (mem_wr && mem_dst == d_rd));
    assign haz_rs = reads_rs && ((ex_wr && ex_rd == d_rs) || (mem_wr && mem_dst == d_rs));
    assign stall  = fetch_valid && (haz_rd || haz_rs);

    // bubble on stall or flush
    assign advance = fetch_valid && !stall && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
            mem_wr   <= 1'b0;
        end else begin
            if (wb_we) begin
                regs[wb_rd] <= wb_data;
            end
            ex_valid <= advance;
            ex_wr    <= advance && op_writes(d_op);
            mem_wr   <= ex_wr;
        end
    end

    // decode/execute payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_op  <= d_op;
            ex_rd  <= d_rd;
            ex_a   <= rd_val;
            ex_b   <= rs_val;
            ex_imm <= instr[7:0];
            ex_pc  <= fetch_pc;
        end
        mem_dst <= ex_rd;
    end

endmodule

// File: logic/execute_unit.sv
/*
 * execute unit
 * add, subtract and address generation, beqz resolution
 * and the execute/memory pipeline register
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module execute_unit import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  opcode_t              ex_op,
    input  logic [1:0]           ex_rd,
    input  logic [`DATA_W-1:0]   ex_a,
    input  logic [`DATA_W-1:0]   ex_b,
    input  logic [7:0]           ex_imm,
    input  logic [`PC_W-1:0]     ex_pc,
    input  logic                 ex_valid,
    output logic                 flush,
    output logic [`PC_W-1:0]     branch_target,
    output opcode_t              mem_op,
    output logic [1:0]           mem_rd,
    output logic [`DATA_W-1:0]   mem_result,
    output logic [`DATA_W-1:0]   mem_store_data,
    output logic                 mem_valid
);

    logic [`DATA_W-1:0] result;

    // alu, ld and st get their address from rs plus imm
    always_comb begin
        case (ex_op)
            op_addi: result = ex_b + ex_imm;
            op_add:  result = ex_a + ex_b;
            op_sub:  result = ex_a - ex_b;
            op_ld:   result = ex_b + ex_imm;
            op_st:   result = ex_b + ex_imm;
            default: result = '0;
        endcase
    end

    // taken beqz kills the two younger words
    assign flush         = ex_valid && ex_op == op_beqz && ex_a == '0;
    // imm wraps modulo the pc range
    assign branch_target = ex_pc + ex_imm[`PC_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    // execute/memory payload
    always_ff @(posedge clk) begin
        mem_op         <= ex_op;
        mem_rd         <= ex_rd;
        mem_result     <= result;
        mem_store_data <= ex_a;
    end

endmodule

// File: logic/memory_unit.sv
/*
 * memory unit
 * data memory access, memory/writeback register and halt detection
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module memory_unit import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  opcode_t              mem_op,
    input  logic [1:0]           mem_rd,
    input  logic [`DATA_W-1:0]   mem_result,
    input  logic [`DATA_W-1:0]   mem_store_data,
    input  logic                 mem_valid,
    output logic                 wb_we,
    output logic [1:0]           wb_rd,
    output logic [`DATA_W-1:0]   wb_data,
    output logic                 wb_valid,
    output logic                 halted
);

    localparam int DADDR_W = $clog2(`DMEM_DEPTH);

    logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
    logic [DADDR_W-1:0] addr;
    logic               wb_halt;
    run_state_t         state;

    // low bits of rs plus imm
    assign addr = mem_result[DADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_op == op_st) begin
            dmem[addr] <= mem_store_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory/writeback register and run state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            wb_halt  <= 1'b0;
            state    <= run_idle;
        end else begin
            wb_valid <= mem_valid;
            wb_we    <= mem_valid && op_writes(mem_op);
            wb_halt  <= mem_valid && mem_op == op_halt;
            case (state)
                run_idle:   if (mem_valid) state <= run_active;
                // halted one cycle after the halt sits in writeback
                run_active: if (wb_halt) state <= run_halted;
                default:    state <= run_halted;
            endcase
        end
    end

    // store retires with rd's value, load with memory data
    always_ff @(posedge clk) begin
        wb_rd <= mem_rd;
        case (mem_op)
            op_ld:   wb_data <= dmem[addr];
            op_st:   wb_data <= mem_store_data;
            default: wb_data <= mem_result;
        endcase
    end

    assign halted = state == run_halted;

endmodule

// File: logic/pipeline_tracker.sv
/*
 * pipeline tracker
 * shadow pipeline of sequence tag, pc, fetch cycle and decode stalls,
 * presenting one retirement record per writeback
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module pipeline_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 fetch_valid,
    input  logic [`PC_W-1:0]     fetch_pc,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 wb_valid,
    input  logic [1:0]           wb_rd,
    input  logic [`DATA_W-1:0]   wb_data,
    output logic                 retire_valid,
    output logic [`TAG_W-1:0]    retire_tag,
    output logic [`PC_W-1:0]     retire_pc,
    output logic [`CYC_W-1:0]    retire_fetch_cycle,
    output logic [`STALL_W-1:0]  retire_stalls,
    output logic [1:0]           retire_rd,
    output logic [`DATA_W-1:0]   retire_data
);

    logic                active;
    logic                issue;
    logic [`CYC_W-1:0]   cyc_cnt;
    logic [`TAG_W-1:0]   tag_cnt;
    // shadow stages, d is the fetch/decode register
    logic [`TAG_W-1:0]   d_tag, e_tag, m_tag, w_tag;
    logic [`CYC_W-1:0]   d_cyc, e_cyc, m_cyc, w_cyc;
    logic [`STALL_W-1:0] d_stl, e_stl, m_stl, w_stl;
    logic [`PC_W-1:0]    e_pc, m_pc, w_pc;
    logic                e_v, m_v, w_v;

    // a fetch slot is used when not stalled, a flushed slot still burns its tag
    assign issue = active && (!stall || flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            cyc_cnt <= '0;
            tag_cnt <= '0;
            e_v     <= 1'b0;
            m_v     <= 1'b0;
            w_v     <= 1'b0;
        end else begin
            // cycle zero follows start
            if (start && !active) begin
                active  <= 1'b1;
                cyc_cnt <= '0;
            end else if (active) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
            if (issue) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
            e_v <= fetch_valid && !stall && !flush;
            m_v <= e_v;
            w_v <= m_v;
        end
    end

    ////////////////////////////////////////////////////////////
    // shadow payload, follows the core register by register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (issue) begin
            d_tag <= tag_cnt;
            d_cyc <= cyc_cnt;
            d_stl <= '0;
        end else if (stall && d_stl != '1) begin
            d_stl <= d_stl + 1'b1;
        end
        e_tag <= d_tag;
        e_cyc <= d_cyc;
        e_stl <= d_stl;
        e_pc  <= fetch_pc;
        m_tag <= e_tag;
        m_cyc <= e_cyc;
        m_stl <= e_stl;
        m_pc  <= e_pc;
        w_tag <= m_tag;
        w_cyc <= m_cyc;
        w_stl <= m_stl;
        w_pc  <= m_pc;
    end

    // record straight off the writeback stage
    assign retire_valid       = wb_valid && w_v;
    assign retire_tag         = w_tag;
    assign retire_pc          = w_pc;
    assign retire_fetch_cycle = w_cyc;
    assign retire_stalls      = w_stl;
    assign retire_rd          = wb_rd;
    assign retire_data        = wb_data;

endmodule

// File: logic/cpu_top.sv
/*
 * cpu top
 * five-stage in-order core with its retirement tracker
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module cpu_top import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 prog_we,
    input  logic [`PC_W-1:0]     prog_addr,
    input  logic [`INSTR_W-1:0]  prog_data,
    output logic                 retire_valid,
    output logic [`TAG_W-1:0]    retire_tag,
    output logic [`PC_W-1:0]     retire_pc,
    output logic [`CYC_W-1:0]    retire_fetch_cycle,
    output logic [`STALL_W-1:0]  retire_stalls,
    output logic [1:0]           retire_rd,
    output logic [`DATA_W-1:0]   retire_data,
    output logic                 halted
);

    // fetch to decode
    logic [`INSTR_W-1:0] instr;
    logic [`PC_W-1:0]    fetch_pc;
    logic                fetch_valid;
    // pipeline control
    logic                stall;
    logic                flush;
    logic [`PC_W-1:0]    branch_target;
    // decode to execute
    opcode_t             ex_op;
    logic [1:0]          ex_rd;
    logic [`DATA_W-1:0]  ex_a;
    logic [`DATA_W-1:0]  ex_b;
    logic [7:0]          ex_imm;
    logic [`PC_W-1:0]    ex_pc;
    logic                ex_valid;
    // execute to memory
    opcode_t             mem_op;
    logic [1:0]          mem_rd;
    logic [`DATA_W-1:0]  mem_result;
    logic [`DATA_W-1:0]  mem_store_data;
    logic                mem_valid;
    // writeback
    logic                wb_we;
    logic [1:0]          wb_rd;
    logic [`DATA_W-1:0]  wb_data;
    logic                wb_valid;

    fetch_unit u_fetch (
        .clk, .rst, .start, .prog_we, .prog_addr, .prog_data,
        .stall, .flush, .branch_target,
        .instr, .fetch_pc, .fetch_valid
    );

    decode_unit u_decode (
        .clk, .rst, .instr, .fetch_pc, .fetch_valid, .flush,
        .wb_we, .wb_rd, .wb_data,
        .ex_op, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc, .ex_valid, .stall
    );

    execute_unit u_execute (
        .clk, .rst, .ex_op, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc, .ex_valid,
        .flush, .branch_target,
        .mem_op, .mem_rd, .mem_result, .mem_store_data, .mem_valid
    );

    memory_unit u_memory (
        .clk, .rst, .mem_op, .mem_rd, .mem_result, .mem_store_data, .mem_valid,
        .wb_we, .wb_rd, .wb_data, .wb_valid, .halted
    );

    pipeline_tracker u_tracker (
        .clk, .rst, .start, .fetch_valid, .fetch_pc, .stall, .flush,
        .wb_valid, .wb_rd, .wb_data,
        .retire_valid, .retire_tag, .retire_pc, .retire_fetch_cycle,
        .retire_stalls, .retire_rd, .retire_data
    );

endmodule

// File: dv/cpu_checker.sv
/*
 * cpu checker
 * concurrent checks on stall, flush, retirement and halt, bound into cpu_top
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module cpu_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 stall,
    input logic                 flush,
    input logic                 fetch_valid,
    input logic                 ex_valid,
    input logic                 mem_valid,
    input logic                 retire_valid,
    input logic [`TAG_W-1:0]    retire_tag,
    input logic                 halted
);

    // count of failed assertions
    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // retirement
    ////////////////////////////////////////////////////////////

    // back to back retires carry new tags
    a_retire_once: assert property (@(posedge clk) disable iff (rst)
        retire_valid && $past(retire_valid) |-> retire_tag != $past(retire_tag))
    else begin
        $error("retirement record held for more than one cycle");
        fail_cnt++;
    end

    // nothing retires once halted is up
    a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !retire_valid)
    else begin
        $error("instruction retired after halted");
        fail_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // pipeline control
    ////////////////////////////////////////////////////////////

    // a stall needs a real decode word and a valid older instruction ahead of it
    a_stall_valid: assert property (@(posedge clk) disable iff (rst)
        stall |-> fetch_valid && (ex_valid || mem_valid))
    else begin
        $error("stall raised without a valid decode word and a valid older instruction");
        fail_cnt++;
    end

    // a taken beqz empties fetch and decode on the next cycle
    a_flush_kills: assert property (@(posedge clk) disable iff (rst)
        flush |=> !fetch_valid && !ex_valid)
    else begin
        $error("flush left a valid word in fetch or decode");
        fail_cnt++;
    end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .ex_valid     (ex_valid),
    .mem_valid    (mem_valid),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .halted       (halted)
);

// File: dv/cpu_tb.sv
/*
 * cpu testbench
 * loads each program from the tests file, runs the core to halt and
 * compares every retirement record with the expected list
 */
`timescale 1ns/100ps
`include "pipe_consts.svh"

module cpu_tb;

    localparam int CLK_PERIOD = 40;
    localparam int MEM_WORDS  = 256;
    // words per expected record as tag pc cycle stalls rd data
    localparam int REC_W      = 6;

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic                 prog_we;
    logic [`PC_W-1:0]     prog_addr;
    logic [`INSTR_W-1:0]  prog_data;
    logic                 retire_valid;
    logic [`TAG_W-1:0]    retire_tag;
    logic [`PC_W-1:0]     retire_pc;
    logic [`CYC_W-1:0]    retire_fetch_cycle;
    logic [`STALL_W-1:0]  retire_stalls;
    logic [1:0]           retire_rd;
    logic [`DATA_W-1:0]   retire_data;
    logic                 halted;

    logic [15:0] tests_mem [MEM_WORDS];
    int          total_words;
    int          err_cnt;
    int          rec_total;
    bit          ready;

    cpu_top uut (
        .clk, .rst, .start, .prog_we, .prog_addr, .prog_data,
        .retire_valid, .retire_tag, .retire_pc, .retire_fetch_cycle,
        .retire_stalls, .retire_rd, .retire_data, .halted
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sum of program lengths over all tests
    function automatic int program_words(int n_tests);
        int pos;
        int sum;
        pos = 1;
        sum = 0;
        for (int t = 0; t < n_tests; t++) begin
            sum += tests_mem[pos];
            pos += 2 + tests_mem[pos] + REC_W * tests_mem[pos + 1];
        end
        return sum;
    endfunction

    task automatic reset_core();
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // program words go in one per cycle ahead of the start strobe
    task automatic load_and_start(int base, int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[`PC_W-1:0];
            prog_data = tests_mem[base + i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        start   = 1'b1;
        @(negedge clk);
        start   = 1'b0;
    endtask

    task automatic check_field(string name, logic [15:0] got, logic [15:0] exp, int t, int r);
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h (test %0d record %0d)", name, got, exp, t, r);
            err_cnt++;
        end
    endtask

    task automatic compare_record(int idx, int t, int r);
        check_field("retire_tag", retire_tag, tests_mem[idx], t, r);
        check_field("retire_pc", retire_pc, tests_mem[idx + 1], t, r);
        check_field("retire_fetch_cycle", retire_fetch_cycle, tests_mem[idx + 2], t, r);
        check_field("retire_stalls", retire_stalls, tests_mem[idx + 3], t, r);
        check_field("retire_rd", retire_rd, tests_mem[idx + 4], t, r);
        check_field("retire_data", retire_data, tests_mem[idx + 5], t, r);
    endtask

    ////////////////////////////////////////////////////////////
    // each test resets, loads and runs to halt plus a short tail
    ////////////////////////////////////////////////////////////
    task automatic run_test(int t, int base);
        int prog_len;
        int rec_cnt;
        int rec_base;
        int got;
        int errs_before;
        int cycles;
        int limit;
        int tail;
        bit halt_due;
        prog_len    = tests_mem[base];
        rec_cnt     = tests_mem[base + 1];
        rec_base    = base + 2 + prog_len;
        limit       = 8 * prog_len + 20;
        errs_before = err_cnt;
        got         = 0;
        cycles      = 0;
        tail        = 0;
        halt_due    = 1'b0;
        reset_core();
        load_and_start(base + 2, prog_len);
        // registered outputs are stable at the falling edge
        while (tail < 4 && cycles < limit) begin
            @(negedge clk);
            // halted follows the last record by one cycle
            if (halt_due) begin
                assert (halted) else begin
                    $display("test %0d: halted did not rise after the halt retired", t);
                    err_cnt++;
                end
                halt_due = 1'b0;
            end
            if (retire_valid) begin
                assert (!halted) else begin
                    $display("test %0d: a record retired after halted went high", t);
                    err_cnt++;
                end
                assert (got < rec_cnt) else begin
                    $display("test %0d: more records retired than the %0d expected", t, rec_cnt);
                    err_cnt++;
                end
                if (got < rec_cnt) begin
                    compare_record(rec_base + REC_W * got, t, got);
                end
                got++;
                halt_due = (got == rec_cnt);
            end
            if (halted) begin
                tail++;
            end
            cycles++;
        end
        assert (halted) else begin
            $display("test %0d: core did not halt within %0d cycles", t, limit);
            err_cnt++;
        end
        assert (got >= rec_cnt) else begin
            $display("test %0d: only %0d of %0d records retired", t, got, rec_cnt);
            err_cnt++;
        end
        rec_total += got;
        $display("test %0d: %0d records, %0d errors", t, got, err_cnt - errs_before);
    endtask

    // watchdog sized from the program lengths in the tests file
    initial begin
        int limit;
        wait (ready);
        limit = total_words * 8 + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int pos;
        int n_tests;
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        err_cnt   = 0;
        rec_total = 0;
        $readmemh("dv/cpu_tests.txt", tests_mem);
        n_tests     = tests_mem[0];
        total_words = program_words(n_tests);
        ready       = 1'b1;
        pos         = 1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t, pos);
            pos += 2 + tests_mem[pos] + REC_W * tests_mem[pos + 1];
        end
        err_cnt += uut.u_checker.fail_cnt;
        $display("%0d tests, %0d records, %0d errors", n_tests, rec_total, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: dv/cpu_tests.txt
// first word is the test count; each test line: program length, record count, program words
// each record line: tag pc fetch_cycle stalls rd data
4
// independent addi and add, consecutive tags, no stalls
6 6 1405 1807 1C09 0000 2600 7000
0 0 0 0 1 05
1 1 1 0 2 07
2 2 2 0 3 09
3 3 3 0 0 00
4 4 4 0 1 0C
5 5 5 0 0 00
// consumer one behind stalls 2, two behind stalls 1
5 5 1403 1904 1C01 1210 7000
0 0 0 0 1 03
1 1 1 2 2 07
2 2 4 0 3 01
3 3 5 1 0 17
4 4 7 0 0 00
// not-taken beqz then taken beqz to pc 8, tags 5 and 6 skipped
A 7 1402 0000 0000 6405 6004 1855 1C66 1877 1C21 7000
0 0 0 0 1 02
1 1 1 0 0 00
2 2 2 0 0 00
3 3 3 0 1 00
4 4 4 0 0 00
7 8 7 0 3 21
8 9 8 0 0 00
// store then load of address 8, sub wraps to C9
6 6 143C 1805 5603 4C08 3900 7000
0 0 0 0 1 3C
1 1 1 0 2 05
2 2 2 2 1 3C
3 3 5 0 3 3C
4 4 6 0 2 C9
5 5 7 0 0 00

// File: src.f
+incdir+include
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/pipeline_tracker.sv
logic/cpu_top.sv
dv/cpu_checker.sv
dv/cpu_tb.sv
